/* verilog/oldland_pkg.sv */
package oldland_pkg;

// ---------------------------------------------------------------------------
// vector types
// ---------------------------------------------------------------------------
typedef logic [31:0] word_t;		// instructions, data and addresses
typedef logic [2:0]  reg_sel_t;		// one of the eight general registers
typedef logic [1:0]  class_t;		// instruction class, bits 31:30
typedef logic [3:0]  opcode_t;		// opcode within a class, bits 29:26
typedef logic [3:0]  alu_opc_t;		// arithmetic opcodes plus the pass-through
typedef logic [2:0]  branch_cond_t;	// condition evaluated in execute
typedef logic [1:0]  mem_width_t;	// access width on the data bus

// instruction classes, class 3 decodes to nothing and acts as a nop
localparam class_t class_arith  = 2'd0;
localparam class_t class_branch = 2'd1;
localparam class_t class_mem    = 2'd2;

// arithmetic opcodes, the ALU takes these unchanged
localparam opcode_t opcode_add   = 4'd0;
localparam opcode_t opcode_sub   = 4'd1;
localparam opcode_t opcode_lsl   = 4'd2;
localparam opcode_t opcode_lsr   = 4'd3;
localparam opcode_t opcode_and   = 4'd4;
localparam opcode_t opcode_xor   = 4'd5;
localparam opcode_t opcode_or    = 4'd6;
localparam opcode_t opcode_cmp   = 4'd7;
localparam opcode_t opcode_mov   = 4'd8;
localparam opcode_t opcode_movhi = 4'd9;

// branch class opcodes
localparam opcode_t opcode_call = 4'd0;
localparam opcode_t opcode_ret  = 4'd1;
localparam opcode_t opcode_b    = 4'd2;
localparam opcode_t opcode_bne  = 4'd3;
localparam opcode_t opcode_beq  = 4'd4;
localparam opcode_t opcode_bgt  = 4'd5;
localparam opcode_t opcode_blt  = 4'd6;

localparam alu_opc_t alu_pass_a = 4'd15;	// result is operand one untouched

localparam branch_cond_t branch_none   = 3'd0;
localparam branch_cond_t branch_ne     = 3'd1;
localparam branch_cond_t branch_eq     = 3'd2;
localparam branch_cond_t branch_gt     = 3'd3;
localparam branch_cond_t branch_lt     = 3'd4;
localparam branch_cond_t branch_always = 3'd7;

localparam mem_width_t width_byte = 2'd0;
localparam mem_width_t width_half = 2'd1;
localparam mem_width_t width_word = 2'd2;

localparam reg_sel_t link_reg  = 3'd6;			// call writes it, ret reads it
localparam word_t    nop_instr = {2'b11, 30'd0};	// class 3 filler between instructions

endpackage

/* verilog/oldland_fetch.sv */
`timescale 1ns/1ps

module oldland_fetch import oldland_pkg::*; #(
	parameter word_t reset_pc = 32'h0000_0000
) (
	input  logic  clk,
	input  logic  reset,
	input  word_t i_data,
	input  logic  retire,
	input  logic  branch_taken,
	input  word_t branch_target,
	output word_t i_addr,
	output word_t instr,
	output word_t pc_plus_4
);

// one instruction in flight, the FSM walks through its four cycles and
// then parks in wb_s until writeback reports the retire
typedef enum logic [1:0] {fetch_s, decode_s, exec_s, wb_s} state_t;

state_t state;
state_t next_state;
word_t pc;

assign i_addr = pc;	// instruction memory answers in the same cycle

always_comb begin
	next_state = state;
	case (state)
	fetch_s:  next_state = decode_s;
	decode_s: next_state = exec_s;
	exec_s:   next_state = wb_s;
	wb_s:     if (retire) next_state = fetch_s;
	default:  next_state = fetch_s;
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= fetch_s;
		pc    <= reset_pc;
		instr <= nop_instr;
	end else begin
		state <= next_state;
		// the decoder only sees the real word for one cycle, the nop keeps
		// its registered controls quiet in every other cycle
		instr <= (state == fetch_s) ? i_data : nop_instr;
		if (state == wb_s && retire)
			pc <= branch_taken ? branch_target : pc + 32'd4;	// redirect or step
	end
end

// return address and base for relative branches, follows instr down the stages
always_ff @(posedge clk) begin
	if (state == fetch_s)
		pc_plus_4 <= pc + 32'd4;
end

endmodule

/* verilog/oldland_decode.sv */
`timescale 1ns/1ps

module oldland_decode import oldland_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  word_t        instr,
	output reg_sel_t     ra_sel,
	output reg_sel_t     rb_sel,
	output reg_sel_t     rd_sel,
	output logic         update_rd,
	output word_t        imm32,
	output alu_opc_t     alu_opc,
	output branch_cond_t branch_condition,
	output logic         alu_op1_ra,
	output logic         alu_op2_rb,
	output logic         mem_load,
	output logic         mem_store,
	output mem_width_t   mem_width,
	input  word_t        pc_plus_4,
	output word_t        pc_plus_4_out,
	output class_t       instr_class,
	output logic         is_call,
	output logic         update_flags
);

class_t cls;
opcode_t opcode;
word_t imm16;
word_t imm24;
logic is_branch;
logic is_ret;
logic reg_target;

assign cls        = instr[31:30];
assign opcode     = instr[29:26];
assign is_branch  = cls == class_branch;
assign is_ret     = is_branch && opcode == opcode_ret;
assign reg_target = is_branch && instr[25];	// target taken from ra

// sign extended immediates, branch offsets count words
assign imm16 = {{16{instr[25]}}, instr[25:10]};
assign imm24 = {{6{instr[23]}}, instr[23:0], 2'b00};

// register selects go straight to the register file, ret needs the link register
assign ra_sel = is_ret ? link_reg : instr[5:3];
assign rb_sel = instr[2:0];

initial begin
	alu_opc          = 4'd0;
	update_rd        = 1'b0;
	branch_condition = branch_none;
	imm32            = 32'd0;
	alu_op1_ra       = 1'b0;
	alu_op2_rb       = 1'b0;
	mem_load         = 1'b0;
	mem_store        = 1'b0;
	mem_width        = width_byte;
	rd_sel           = 3'd0;
	pc_plus_4_out    = 32'd0;
	is_call          = 1'b0;
	instr_class      = 2'd0;
	update_flags     = 1'b0;
end

// ---------------------------------------------------------------------------
// strobes, cleared by reset so execute sees no stray access or write
// ---------------------------------------------------------------------------
always @(posedge clk) begin
	if (reset) begin
		update_rd    <= 1'b0;
		update_flags <= 1'b0;
		mem_load     <= 1'b0;
		mem_store    <= 1'b0;
	end else begin
		// cmp only sets the flags, loads write rd later from writeback
		update_rd    <= (cls == class_arith && opcode != opcode_cmp) ||
				(is_branch && opcode == opcode_call);
		update_flags <= cls == class_arith && opcode == opcode_cmp;
		mem_load     <= cls == class_mem && !instr[28];
		mem_store    <= cls == class_mem && instr[28];	// bit 28 marks a store
	end
end

// ---------------------------------------------------------------------------
// payload for the execute stage
// ---------------------------------------------------------------------------
always @(posedge clk) begin
	branch_condition <= branch_none;
	if (is_branch) begin
		case (opcode)
		opcode_bne: branch_condition <= branch_ne;
		opcode_beq: branch_condition <= branch_eq;
		opcode_bgt: branch_condition <= branch_gt;
		opcode_blt: branch_condition <= branch_lt;
		default:    branch_condition <= branch_always;	// call, ret and b
		endcase
	end

	// a register target rides through the ALU as operand one
	alu_opc <= (cls == class_arith) ? opcode :
		(reg_target || is_ret) ? alu_pass_a : opcode_add;

	// movhi puts its immediate in the upper half
	imm32 <= is_branch ? imm24 :
		(cls == class_arith && opcode == opcode_movhi) ? {instr[25:10], 16'd0} : imm16;

	alu_op1_ra  <= cls == class_arith || cls == class_mem || is_ret || reg_target;
	alu_op2_rb  <= cls == class_arith && instr[9];
	rd_sel      <= (is_branch && opcode == opcode_call) ? link_reg : instr[8:6];
	instr_class <= cls;
	is_call     <= is_branch && opcode == opcode_call;

	case (instr[27:26])
	2'b00:   mem_width <= width_word;
	2'b01:   mem_width <= width_half;
	default: mem_width <= width_byte;
	endcase

	pc_plus_4_out <= pc_plus_4;	// for relative targets and the call link value
end

endmodule

/* verilog/oldland_regfile.sv */
`timescale 1ns/1ps

module oldland_regfile import oldland_pkg::*; (
	input  logic     clk,
	input  reg_sel_t ra_sel,
	input  reg_sel_t rb_sel,
	input  logic     wr_en,
	input  reg_sel_t wr_sel,
	input  word_t    wr_data,
	output word_t    ra_data,
	output word_t    rb_data
);

word_t regs [0:7];	// r6 doubles as the link register

// both read ports are asynchronous, decode drives the selects in its own cycle
assign ra_data = regs[ra_sel];
assign rb_data = regs[rb_sel];

// writeback lands at the edge that closes the writeback cycle, before the
// next instruction reaches decode
always_ff @(posedge clk) begin
	if (wr_en)
		regs[wr_sel] <= wr_data;
end

endmodule

/* verilog/oldland_alu.sv */
`timescale 1ns/1ps

module oldland_alu import oldland_pkg::*; (
	input  alu_opc_t opc,
	input  word_t    op1,
	input  word_t    op2,
	output word_t    result,
	output logic     zero,
	output logic     borrow
);

logic [32:0] diff;	// extra bit holds the borrow out
logic [4:0] shamt;

// the flags always come from the subtraction, only cmp decides to keep them
assign diff   = {1'b0, op1} - {1'b0, op2};
assign zero   = diff[31:0] == 32'd0;
assign borrow = diff[32];	// op1 below op2, unsigned
assign shamt  = op2[4:0];

always_comb begin
	case (opc)
	opcode_add:   result = op1 + op2;
	opcode_sub:   result = diff[31:0];
	opcode_lsl:   result = op1 << shamt;
	opcode_lsr:   result = op1 >> shamt;
	opcode_and:   result = op1 & op2;
	opcode_xor:   result = op1 ^ op2;
	opcode_or:    result = op1 | op2;
	opcode_cmp:   result = diff[31:0];	// result dropped, decode blocks the write
	opcode_mov:   result = op2;
	opcode_movhi: result = op2;		// decode already shifted the immediate
	alu_pass_a:   result = op1;		// register branch targets and ret
	default:      result = 32'd0;
	endcase
end

endmodule

/* verilog/oldland_exec.sv */
`timescale 1ns/1ps

module oldland_exec import oldland_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  reg_sel_t     rd_sel,
	input  logic         update_rd,
	input  word_t        imm32,
	input  alu_opc_t     alu_opc,
	input  branch_cond_t branch_condition,
	input  logic         alu_op1_ra,
	input  logic         alu_op2_rb,
	input  logic         mem_load,
	input  logic         mem_store,
	input  mem_width_t   mem_width,
	input  class_t       instr_class,
	input  logic         is_call,
	input  logic         update_flags,
	input  word_t        ra_data,
	input  word_t        rb_data,
	input  word_t        pc_plus_4,
	output word_t        d_addr,
	output word_t        d_wr_data,
	output logic         d_wr_en,
	output logic         d_rd_en,
	output logic [3:0]   d_bytesel,
	output logic         branch_taken,
	output word_t        branch_target,
	output logic         wb_en,
	output reg_sel_t     wb_sel,
	output word_t        wb_value,
	output logic         wb_load,
	output mem_width_t   wb_width,
	output logic [1:0]   wb_offset
);

word_t ra_q, rb_q;	// operands read in the decode cycle
word_t op1, op2, result, st_data;
logic zero, borrow, z_flag, c_flag, cond_met;
logic [3:0] lanes;

// the selects are only valid while decode holds the instruction, so the
// read data is captured alongside the decode controls
always_ff @(posedge clk) begin
	ra_q <= ra_data;
	rb_q <= rb_data;
end

assign op1 = alu_op1_ra ? ra_q : 32'd0;
assign op2 = alu_op2_rb ? rb_q : imm32;

oldland_alu u_alu (
	.opc(alu_opc),
	.op1(op1),
	.op2(op2),
	.result(result),
	.zero(zero),
	.borrow(borrow)
);

// conditions look at the flags left by an earlier cmp
always_comb begin
	case (branch_condition)
	branch_ne:     cond_met = !z_flag;
	branch_eq:     cond_met = z_flag;
	branch_gt:     cond_met = !z_flag && !c_flag;
	branch_lt:     cond_met = c_flag;
	branch_always: cond_met = 1'b1;
	default:       cond_met = 1'b0;
	endcase
end

// store data is copied to every lane, the strobes pick the live ones
always_comb begin
	case (mem_width)
	width_byte: begin
		lanes   = 4'b0001 << result[1:0];
		st_data = {4{rb_q[7:0]}};
	end
	width_half: begin
		lanes   = result[1] ? 4'b1100 : 4'b0011;
		st_data = {2{rb_q[15:0]}};
	end
	default: begin
		lanes   = 4'b1111;
		st_data = rb_q;
	end
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		d_wr_en      <= 1'b0;
		d_rd_en      <= 1'b0;
		branch_taken <= 1'b0;
		wb_en        <= 1'b0;
		wb_load      <= 1'b0;
		z_flag       <= 1'b0;
		c_flag       <= 1'b0;
	end else begin
		d_wr_en      <= mem_store;	// one cycle wide, the decode strobes are
		d_rd_en      <= mem_load;
		branch_taken <= instr_class == class_branch && cond_met;
		wb_en        <= update_rd || mem_load;
		wb_load      <= mem_load;
		if (update_flags) begin
			z_flag <= zero;
			c_flag <= borrow;
		end
	end
end

always_ff @(posedge clk) begin
	d_addr        <= result;	// ra plus offset for memory accesses
	d_wr_data     <= st_data;
	d_bytesel     <= lanes;
	branch_target <= (alu_opc == alu_pass_a) ? result : pc_plus_4 + imm32;
	wb_sel        <= rd_sel;
	wb_value      <= is_call ? pc_plus_4 : result;	// call links the return address
	wb_width      <= mem_width;
	wb_offset     <= result[1:0];
end

endmodule

/* verilog/oldland_writeback.sv */
`timescale 1ns/1ps

module oldland_writeback import oldland_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       wb_en,
	input  reg_sel_t   wb_sel,
	input  word_t      wb_value,
	input  logic       wb_load,
	input  mem_width_t wb_width,
	input  logic [1:0] wb_offset,
	input  word_t      d_rd_data,
	output logic       rf_wr_en,
	output reg_sel_t   rf_wr_sel,
	output word_t      rf_wr_data,
	output logic       retire
);

logic [1:0] phase;	// position inside the four cycle instruction slot
logic [15:0] ld_half;
logic [7:0] ld_byte;
word_t load_data;

// counts in step with the fetch FSM from reset, the last slot cycle is ours
always_ff @(posedge clk) begin
	if (reset)
		phase <= 2'd0;
	else
		phase <= phase + 2'd1;
end

assign retire = phase == 2'd3;	// also for instructions that write nothing

// pick the addressed lanes out of the word the data memory returned
assign ld_half = wb_offset[1] ? d_rd_data[31:16] : d_rd_data[15:0];
assign ld_byte = d_rd_data[8 * wb_offset +: 8];

always_comb begin
	case (wb_width)
	width_byte: load_data = {24'd0, ld_byte};
	width_half: load_data = {16'd0, ld_half};
	default:    load_data = d_rd_data;
	endcase
end

assign rf_wr_en   = wb_en;
assign rf_wr_sel  = wb_sel;
assign rf_wr_data = wb_load ? load_data : wb_value;

endmodule

/* verilog/oldland_cpu.sv */
`timescale 1ns/1ps

module oldland_cpu import oldland_pkg::*; #(
	parameter word_t reset_pc = 32'h0000_0000
) (
	input  logic       clk,
	input  logic       reset,
	output word_t      i_addr,
	input  word_t      i_data,
	output word_t      d_addr,
	output word_t      d_wr_data,
	input  word_t      d_rd_data,
	output logic       d_wr_en,
	output logic       d_rd_en,
	output logic [3:0] d_bytesel,
	output logic       retire_valid,
	output reg_sel_t   retire_sel,
	output word_t      retire_data
);

// ---------------------------------------------------------------------------
// stage to stage wiring
// ---------------------------------------------------------------------------
word_t instr, fetch_pc_plus_4, dec_pc_plus_4;
reg_sel_t ra_sel, rb_sel, rd_sel;
word_t ra_data, rb_data, imm32;
logic update_rd, alu_op1_ra, alu_op2_rb, mem_load, mem_store, is_call, update_flags;
alu_opc_t alu_opc;
branch_cond_t branch_condition;
mem_width_t mem_width;
class_t instr_class;
logic branch_taken, retire;
word_t branch_target;
logic wb_en, wb_load;
reg_sel_t wb_sel;
word_t wb_value;
mem_width_t wb_width;
logic [1:0] wb_offset;

oldland_fetch #(.reset_pc(reset_pc)) u_fetch (
	.clk(clk), .reset(reset), .i_data(i_data), .retire(retire),
	.branch_taken(branch_taken), .branch_target(branch_target),
	.i_addr(i_addr), .instr(instr), .pc_plus_4(fetch_pc_plus_4)
);

oldland_decode u_decode (
	.clk(clk), .reset(reset), .instr(instr), .ra_sel(ra_sel), .rb_sel(rb_sel),
	.rd_sel(rd_sel), .update_rd(update_rd), .imm32(imm32), .alu_opc(alu_opc),
	.branch_condition(branch_condition), .alu_op1_ra(alu_op1_ra),
	.alu_op2_rb(alu_op2_rb), .mem_load(mem_load), .mem_store(mem_store),
	.mem_width(mem_width), .pc_plus_4(fetch_pc_plus_4),
	.pc_plus_4_out(dec_pc_plus_4), .instr_class(instr_class), .is_call(is_call),
	.update_flags(update_flags)
);

// the write port is the retire port seen from outside
oldland_regfile u_regfile (
	.clk(clk), .ra_sel(ra_sel), .rb_sel(rb_sel), .wr_en(retire_valid),
	.wr_sel(retire_sel), .wr_data(retire_data), .ra_data(ra_data), .rb_data(rb_data)
);

oldland_exec u_exec (
	.clk(clk), .reset(reset), .rd_sel(rd_sel), .update_rd(update_rd), .imm32(imm32),
	.alu_opc(alu_opc), .branch_condition(branch_condition), .alu_op1_ra(alu_op1_ra),
	.alu_op2_rb(alu_op2_rb), .mem_load(mem_load), .mem_store(mem_store),
	.mem_width(mem_width), .instr_class(instr_class), .is_call(is_call),
	.update_flags(update_flags), .ra_data(ra_data), .rb_data(rb_data),
	.pc_plus_4(dec_pc_plus_4), .d_addr(d_addr), .d_wr_data(d_wr_data),
	.d_wr_en(d_wr_en), .d_rd_en(d_rd_en), .d_bytesel(d_bytesel),
	.branch_taken(branch_taken), .branch_target(branch_target), .wb_en(wb_en),
	.wb_sel(wb_sel), .wb_value(wb_value), .wb_load(wb_load), .wb_width(wb_width),
	.wb_offset(wb_offset)
);

oldland_writeback u_writeback (
	.clk(clk), .reset(reset), .wb_en(wb_en), .wb_sel(wb_sel), .wb_value(wb_value),
	.wb_load(wb_load), .wb_width(wb_width), .wb_offset(wb_offset),
	.d_rd_data(d_rd_data), .rf_wr_en(retire_valid), .rf_wr_sel(retire_sel),
	.rf_wr_data(retire_data), .retire(retire)
);

endmodule

/* dv/oldland_cpu_assertions.sv */
`timescale 1ns/1ps

// fetch_state carries the fetch FSM encoding with 0 for fetch and 3 for writeback
module oldland_cpu_checker (
	input logic       clk,
	input logic       reset,
	input logic       d_wr_en,
	input logic       d_rd_en,
	input logic [3:0] d_bytesel,
	input logic       retire,
	input logic [1:0] fetch_state
);

// ---------------------------------------------------------------------------
// writeback retire pulse and data bus timing against the fetch FSM
// ---------------------------------------------------------------------------
retire_in_wb: assert property (@(posedge clk) disable iff (reset)
	retire |-> fetch_state == 2'd3) else $error("retire outside the writeback state");
wb_retires: assert property (@(posedge clk) disable iff (reset)
	fetch_state == 2'd3 |-> retire)
	else $error("fetch FSM sat in writeback without a retire");
strobe_in_wb: assert property (@(posedge clk) disable iff (reset)
	(d_wr_en || d_rd_en) |-> fetch_state == 2'd3)
	else $error("data bus access outside the writeback state");

// ---------------------------------------------------------------------------
// memory strobes and the retire pulse
// ---------------------------------------------------------------------------
no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
	!(d_wr_en && d_rd_en)) else $error("read and write strobes high together");
retire_one_cycle: assert property (@(posedge clk) disable iff (reset)
	retire |=> !retire) else $error("retire held for more than one cycle");
store_has_lanes: assert property (@(posedge clk) disable iff (reset)
	d_wr_en |-> d_bytesel != 4'd0) else $error("store with no byte lane enabled");

endmodule

bind oldland_cpu oldland_cpu_checker fsm_bus_check_i (
	.clk(clk),
	.reset(reset),
	.d_wr_en(d_wr_en),
	.d_rd_en(d_rd_en),
	.d_bytesel(d_bytesel),
	.retire(retire),
	.fetch_state(u_fetch.state)
);

/* dv/oldland_cpu_tb.sv */
`timescale 1ns/1ps

module oldland_cpu_tb import oldland_pkg::*; ();

localparam word_t reset_pc = 32'h0000_0040;	// program starts at word 16
localparam int n_instr = 600;			// retires before the run ends
localparam int cycle_limit = 4 * n_instr + 8 + 40;

logic clk, reset;
word_t i_addr, i_data, d_addr, d_wr_data, d_rd_data;
logic d_wr_en, d_rd_en, retire_valid;
logic [3:0] d_bytesel;
reg_sel_t retire_sel;
word_t retire_data;

word_t imem [0:255];	// program shared by the bus model and the reference
word_t dmem [0:255];	// data seen by the DUT
word_t m_mem [0:255];	// data seen by the reference model
word_t m_regs [0:7];
word_t m_pc, rng;
logic m_z, m_c;
logic exp_wr_en, exp_st_en, exp_ld_en;
reg_sel_t exp_wr_sel;
word_t exp_wr_data, exp_addr, exp_st_data;
logic [3:0] exp_lanes;
int retired, gap, cycles;
logic fetch_due;

oldland_cpu #(.reset_pc(reset_pc)) dut_i (
	.clk(clk), .reset(reset), .i_addr(i_addr), .i_data(i_data), .d_addr(d_addr),
	.d_wr_data(d_wr_data), .d_rd_data(d_rd_data), .d_wr_en(d_wr_en), .d_rd_en(d_rd_en),
	.d_bytesel(d_bytesel), .retire_valid(retire_valid), .retire_sel(retire_sel),
	.retire_data(retire_data)
);

always #50 clk = ~clk;

// both memories answer in the same cycle and wrap at 1 KiB
assign i_data = imem[i_addr[9:2]];
assign d_rd_data = dmem[d_addr[9:2]];

always @(posedge clk) begin
	if (d_wr_en)
		for (int k = 0; k < 4; k++)
			if (d_bytesel[k]) dmem[d_addr[9:2]][8*k +: 8] <= d_wr_data[8*k +: 8];
end

function automatic word_t xorshift(input word_t x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

task automatic abort_run(input string line);
	$display("%s", line);
	$display("Result: FAILED");
	$fatal(1);
endtask

task automatic report_mismatch(input string msg);
	abort_run($sformatf("MISMATCH at %0t: %s", $time, msg));
endtask

task automatic check_reg_write(input logic got_en, input reg_sel_t got_sel, input word_t got_data,
		input logic want_en, input reg_sel_t want_sel, input word_t want_data);
	if (got_en !== want_en)
		report_mismatch($sformatf("retire_valid %b, expected %b", got_en, want_en));
	else if (want_en && (got_sel !== want_sel || got_data !== want_data))
		report_mismatch($sformatf("write r%0d=%h, expected r%0d=%h",
			got_sel, got_data, want_sel, want_data));
endtask

task automatic check_store(input logic got_en, input word_t got_addr, input word_t got_data,
		input logic [3:0] got_lanes, input logic want_en, input word_t want_addr,
		input word_t want_data, input logic [3:0] want_lanes);
	if (got_en !== want_en)
		report_mismatch($sformatf("d_wr_en %b, expected %b", got_en, want_en));
	else if (want_en && (got_addr !== want_addr || got_data !== want_data ||
			got_lanes !== want_lanes))
		report_mismatch($sformatf("store %h/%h/%b, expected %h/%h/%b", got_addr, got_data,
			got_lanes, want_addr, want_data, want_lanes));
endtask

task automatic check_load(input logic got_en, input word_t got_addr, input logic want_en,
		input word_t want_addr);
	if (got_en !== want_en)
		report_mismatch($sformatf("d_rd_en %b, expected %b", got_en, want_en));
	else if (want_en && got_addr !== want_addr)
		report_mismatch($sformatf("load from %h, expected %h", got_addr, want_addr));
endtask

task automatic check_fetch(input word_t got_addr, input word_t want_addr);
	if (got_addr !== want_addr)
		report_mismatch($sformatf("fetch from %h, expected %h", got_addr, want_addr));
endtask

// ---------------------------------------------------------------------------
// reference instruction set model called once per retired instruction
// ---------------------------------------------------------------------------
function automatic void step_model();
	word_t ins, a, b, res, imm, tgt, ea, ld;
	opcode_t opc;
	logic taken;
	word_t next_pc;
	ins = imem[m_pc[9:2]];
	opc = ins[29:26];
	imm = {{16{ins[25]}}, ins[25:10]};
	next_pc = m_pc + 32'd4;
	exp_wr_en = 1'b0;
	exp_wr_sel = '0;
	exp_wr_data = '0;
	exp_st_en = 1'b0;
	exp_ld_en = 1'b0;
	exp_addr = '0;
	exp_st_data = '0;
	exp_lanes = '0;
	case (ins[31:30])
	class_arith: begin
		a = m_regs[ins[5:3]];
		if (ins[9]) b = m_regs[ins[2:0]];
		else if (opc == opcode_movhi) b = {ins[25:10], 16'd0};	// immediate in the top half
		else b = imm;
		case (opc)
		opcode_add: res = a + b;
		opcode_lsl: res = a << b[4:0];
		opcode_lsr: res = a >> b[4:0];
		opcode_and: res = a & b;
		opcode_xor: res = a ^ b;
		opcode_or:  res = a | b;
		opcode_mov, opcode_movhi: res = b;
		default:    res = a - b;	// sub and cmp
		endcase
		if (opc == opcode_cmp) begin
			m_z = a == b;	// cmp only moves the flags
			m_c = a < b;
		end else begin
			exp_wr_en = 1'b1;
			exp_wr_sel = ins[8:6];
			exp_wr_data = res;
		end
	end
	class_branch: begin
		case (opc)
		opcode_bne: taken = !m_z;
		opcode_beq: taken = m_z;
		opcode_bgt: taken = !m_z && !m_c;
		opcode_blt: taken = m_c;
		default:    taken = 1'b1;
		endcase
		if (opc == opcode_ret) tgt = m_regs[6];
		else if (ins[25]) tgt = m_regs[ins[5:3]];
		else tgt = m_pc + 32'd4 + {{6{ins[23]}}, ins[23:0], 2'b00};
		if (opc == opcode_call) begin
			exp_wr_en = 1'b1;	// link written after the old r6 was read
			exp_wr_sel = 3'd6;
			exp_wr_data = m_pc + 32'd4;
		end
		if (taken) next_pc = tgt;
	end
	class_mem: begin
		ea = m_regs[ins[5:3]] + imm;
		b = m_regs[ins[2:0]];
		exp_addr = ea;
		case (ins[27:26])
		2'd0: begin exp_lanes = 4'b1111; exp_st_data = b; end
		2'd1: begin exp_lanes = ea[1] ? 4'b1100 : 4'b0011; exp_st_data = {2{b[15:0]}}; end
		default: begin exp_lanes = 4'b0001 << ea[1:0]; exp_st_data = {4{b[7:0]}}; end
		endcase
		if (ins[28]) begin
			exp_st_en = 1'b1;
			for (int k = 0; k < 4; k++)
				if (exp_lanes[k]) m_mem[ea[9:2]][8*k +: 8] = exp_st_data[8*k +: 8];
		end else begin
			exp_ld_en = 1'b1;
			ld = m_mem[ea[9:2]];
			case (ins[27:26])
			2'd0: exp_wr_data = ld;
			2'd1: exp_wr_data = ea[1] ? {16'd0, ld[31:16]} : {16'd0, ld[15:0]};
			default: exp_wr_data = {24'd0, ld[8*ea[1:0] +: 8]};	// zero extended
			endcase
			exp_wr_en = 1'b1;
			exp_wr_sel = ins[8:6];
		end
	end
	default: ;	// class 3 does nothing
	endcase
	m_pc = next_pc;
	if (exp_wr_en) m_regs[exp_wr_sel] = exp_wr_data;
endfunction

// random program where r7 stays zero as the data base and r6 only holds code addresses
task automatic build_program();
	int base, t, kind;
	word_t w;
	base = reset_pc[9:2];
	for (int i = 0; i < 256; i++) begin
		rng = xorshift(rng);
		kind = rng % 16;
		t = (rng >> 8) % 256;
		if (t == i) t = (i + 1) % 256;	// no branch onto itself
		if (i >= base && i < base + 8) begin
			w = (i - base == 7) ? 16'h0 : (i - base == 6) ? 16'h0200 : rng[31:16];
			imem[i] = {2'b00, opcode_mov, w[15:0], 1'b0, 3'(i - base), 6'd0};
		end else if (kind < 9) begin
			// arithmetic with cmp over-weighted so the conditions see fresh flags
			imem[i] = {2'b00, (kind > 6) ? opcode_cmp : opcode_t'(rng[27:24] % 10),
				rng[31:16], rng[5], 3'(rng[23:20] % 6), rng[13:11], rng[10:8]};
		end else if (kind < 12) begin
			w = xorshift(rng);
			if (w[2:0] == 3'd1) imem[i] = {2'b01, opcode_ret, 26'd0};
			else if (w[3]) imem[i] = {2'b01, opcode_t'(w[6:4] % 7), 1'b1, 19'd0, 3'd6, 3'd0};
			else imem[i] = {2'b01, opcode_t'(w[6:4] % 7), 2'b00, 24'(t - i - 1)};
		end else if (kind < 15) begin
			w = rng % 1024;
			case (rng[17:16] % 3)	// width code 0 is word, 1 half and 2 byte
			0: w[1:0] = 2'b00;
			1: w[0] = 1'b0;
			default: ;
			endcase
			imem[i] = {2'b10, 1'b0, rng[20], 2'(rng[17:16] % 3), w[15:0], 1'b0,
				3'(rng[23:21] % 6), 3'd7, rng[26:24]};
		end else begin
			imem[i] = {2'b11, rng[29:0]};	// filler no-operation
		end
	end
endtask

// ---------------------------------------------------------------------------
// compare process sampling on the falling edge when everything is settled
// ---------------------------------------------------------------------------
always @(negedge clk) begin
	if (reset) begin
		gap = 1;
		fetch_due = 1'b1;
	end else begin
		gap = gap + 1;
		if (fetch_due) check_fetch(i_addr, m_pc);	// first fetch is at reset_pc
		fetch_due = 1'b0;
		if (dut_i.retire) begin
			if (gap != 4) abort_run("retire did not come four cycles after the last one");
			gap = 0;
			step_model();
			check_reg_write(retire_valid, retire_sel, retire_data,
				exp_wr_en, exp_wr_sel, exp_wr_data);
			check_store(d_wr_en, d_addr, d_wr_data, d_bytesel,
				exp_st_en, exp_addr, exp_st_data, exp_lanes);
			check_load(d_rd_en, d_addr, exp_ld_en, exp_addr);
			fetch_due = 1'b1;
			retired++;
		end else begin
			if (gap >= 4) abort_run("no retire in the fourth cycle of an instruction");
			if (retire_valid || d_wr_en || d_rd_en)
				abort_run("register write or bus access outside the retire cycle");
		end
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles > cycle_limit) abort_run("timeout waiting for the instructions to retire");
end

initial begin
	clk = 1'b0;
	reset = 1'b1;
	retired = 0;
	cycles = 0;
	rng = 32'h0c16_a26a;
	build_program();
	for (int i = 0; i < 256; i++) begin
		dmem[i] = (i * 32'h0101_0101) ^ 32'ha5c3_0f96;	// every byte tracks the index
		m_mem[i] = dmem[i];
	end
	for (int r = 0; r < 8; r++) m_regs[r] = 'x;
	m_pc = reset_pc;
	m_z = 1'b0;
	m_c = 1'b0;
	repeat (8) @(negedge clk);
	reset <= 1'b0;
	while (retired < n_instr) @(negedge clk);
	@(negedge clk);
	$display("Result: PASSED");
	$finish;
end

endmodule

/* sim.f */
verilog/oldland_pkg.sv
verilog/oldland_fetch.sv
verilog/oldland_decode.sv
verilog/oldland_regfile.sv
verilog/oldland_alu.sv
verilog/oldland_exec.sv
verilog/oldland_writeback.sv
verilog/oldland_cpu.sv
dv/oldland_cpu_assertions.sv
dv/oldland_cpu_tb.sv
